// ==== hdl/mpr121_defines.svh ====
`ifndef MPR121_DEFINES_SVH
`define MPR121_DEFINES_SVH

// 7-bit slave address with ADDR tied to 3Vo
`define MPR121_I2C_ADDR 7'h5B

// clk cycles per quarter scl period
// 125 on the 50 MHz board for 100 kHz scl
// 4 keeps simulation short
`define I2C_PRESCALE 4

// idle cycles after a write stop before busy drops
`define WRITE_SETTLE_CYCLES 125

// bits in one bus byte
`define BYTE_W 8

`endif

// ==== hdl/mpr121_pkg.sv ====
`include "mpr121_defines.svh"

package mpr121_pkg;

	// commands understood by the bit engine
	// start also serves as the repeated start
	typedef enum logic [1:0]
	{
		CMD_START = 2'd0, // start or repeated start
		CMD_WRITE = 2'd1, // 8 bits out then sample ack
		CMD_READ  = 2'd2, // 8 bits in then nack
		CMD_STOP  = 2'd3  // stop condition
	} i2c_cmd_e;

	// one byte on the bus
	// the shifter sees raw and the address phase uses addr_rw
	typedef union packed
	{
		logic [`BYTE_W-1:0] raw; // msb goes out first
		struct packed
		{
			logic [`BYTE_W-2:0] addr; // 7-bit slave address
			logic               rw;   // 1 for read
		} addr_rw;
	} i2c_byte_u;

	// mpr121 register address or register value
	typedef logic [`BYTE_W-1:0] reg_byte_t;

endpackage

// ==== hdl/i2c_bit_engine.sv ====
`timescale 1ns/10ps
`include "mpr121_defines.svh"

module i2c_bit_engine (
	input  logic                  clk,
	input  logic                  rstn,
	input  mpr121_pkg::i2c_cmd_e  cmd,
	input  logic                  cmd_valid,
	input  mpr121_pkg::i2c_byte_u tx_byte,
	input  logic                  sda_in,
	output logic                  done,
	output logic                  ack_in,
	output mpr121_pkg::i2c_byte_u rx_byte,
	output logic                  scl_oe,
	output logic                  sda_oe
);
	localparam int QW = ($clog2(`I2C_PRESCALE) > 0) ? $clog2(`I2C_PRESCALE) : 1;
	localparam int BW = $clog2(`BYTE_W + 1);
	localparam logic [QW-1:0] Q_LAST = QW'(`I2C_PRESCALE - 1);
	localparam logic [BW-1:0] BIT_ACK = BW'(`BYTE_W); // ninth bit index

	logic                  active;  // command in progress
	mpr121_pkg::i2c_cmd_e  cur_cmd; // latched command
	logic [QW-1:0]         q_cnt;   // cycles inside a quarter
	logic [1:0]            qtr;     // quarter inside a bit
	logic [BW-1:0]         bit_cnt; // 0..8 for byte commands
	mpr121_pkg::i2c_byte_u tx_sh;   // outgoing byte
	logic                  q_end;
	logic                  bit_end;
	logic                  cmd_end;
	logic                  sample;
	logic                  scl_drv;
	logic                  sda_drv;

	assign q_end = active && (q_cnt == Q_LAST);
	assign bit_end = q_end && (qtr == 2'd3);

	// start and stop are a single bit time
	assign cmd_end = bit_end && ((cur_cmd == mpr121_pkg::CMD_START) ||
		(cur_cmd == mpr121_pkg::CMD_STOP) || (bit_cnt == BIT_ACK));

	// first cycle of q2 so scl has been high for a full quarter
	assign sample = active && (qtr == 2'd2) && (q_cnt == '0);

	// line drive per quarter
	// scl low in q0 and q3 of every bit
	always_comb
	begin
		scl_drv = 1'b0;
		sda_drv = 1'b0;
		case (cur_cmd)
			mpr121_pkg::CMD_START:
			begin
				scl_drv = (qtr == 2'd0) || (qtr == 2'd3);
				sda_drv = (qtr == 2'd2) || (qtr == 2'd3); // sda falls while scl high
			end
			mpr121_pkg::CMD_STOP:
			begin
				scl_drv = (qtr == 2'd0); // scl up from q1
				sda_drv = (qtr == 2'd0) || (qtr == 2'd1); // sda rises in q2
			end
			mpr121_pkg::CMD_WRITE:
			begin
				scl_drv = (qtr == 2'd0) || (qtr == 2'd3);
				// ninth bit released for the slave ack
				sda_drv = (bit_cnt != BIT_ACK) && !tx_sh.raw[`BYTE_W-1];
			end
			default:
			begin
				// read keeps sda released
				// which also gives the nack on bit nine
				scl_drv = (qtr == 2'd0) || (qtr == 2'd3);
				sda_drv = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			active <= 1'b0;
			cur_cmd <= mpr121_pkg::CMD_START;
			q_cnt <= '0;
			qtr <= 2'd0;
			bit_cnt <= '0;
			done <= 1'b0;
			ack_in <= 1'b0;
			scl_oe <= 1'b0; // both lines released
			sda_oe <= 1'b0;
		end
		else
		begin
			done <= cmd_end; // single cycle since active drops with it
			if (cmd_valid && !active)
			begin
				active <= 1'b1;
				cur_cmd <= cmd;
				q_cnt <= '0;
				qtr <= 2'd0;
				bit_cnt <= '0;
			end
			else if (active)
			begin
				q_cnt <= q_end ? '0 : q_cnt + 1'b1;
				if (q_end)
				begin
					qtr <= qtr + 2'd1; // wraps to q0 of next bit
				end
				if (bit_end)
				begin
					bit_cnt <= bit_cnt + 1'b1;
				end
				if (cmd_end)
				begin
					active <= 1'b0;
				end
				scl_oe <= scl_drv; // lines hold while idle
				sda_oe <= sda_drv;
			end
			// slave pulls sda low to acknowledge
			if (sample && (cur_cmd == mpr121_pkg::CMD_WRITE) && (bit_cnt == BIT_ACK))
			begin
				ack_in <= ~sda_in;
			end
		end
	end

	// byte shifters
	always_ff @(posedge clk)
	begin
		if (cmd_valid && !active)
		begin
			tx_sh <= tx_byte;
		end
		else if (bit_end)
		begin
			tx_sh.raw <= {tx_sh.raw[`BYTE_W-2:0], 1'b0}; // next bit to msb
		end
		if (sample && (cur_cmd == mpr121_pkg::CMD_READ) && (bit_cnt != BIT_ACK))
		begin
			rx_byte.raw <= {rx_byte.raw[`BYTE_W-2:0], sda_in}; // msb first
		end
	end

	// sequencer must wait for done before the next command
	a_cmd_when_idle: assert property (@(posedge clk) disable iff (!rstn)
		cmd_valid |-> !active);

	// sda only moves under low scl outside start and stop
	a_sda_stable: assert property (@(posedge clk) disable iff (!rstn)
		(!scl_oe && !$past(scl_oe) && (cur_cmd != mpr121_pkg::CMD_START) &&
		(cur_cmd != mpr121_pkg::CMD_STOP)) |-> $stable(sda_oe));

endmodule

// ==== hdl/mpr121_sequencer.sv ====
`timescale 1ns/10ps
`include "mpr121_defines.svh"

module mpr121_sequencer (
	input  logic                  clk,
	input  logic                  rstn,
	input  mpr121_pkg::reg_byte_t reg_addr,
	input  mpr121_pkg::reg_byte_t data_in,
	input  logic                  write_enable,
	input  logic                  read_enable,
	input  logic                  done,
	input  logic                  ack_in,
	input  mpr121_pkg::i2c_byte_u rx_byte,
	output mpr121_pkg::reg_byte_t data_out,
	output logic                  busy,
	output logic                  fail,
	output mpr121_pkg::i2c_cmd_e  cmd,
	output logic                  cmd_valid,
	output mpr121_pkg::i2c_byte_u tx_byte
);
	localparam int SW = $clog2(`WRITE_SETTLE_CYCLES + 1);

	typedef enum logic [3:0]
	{
		ST_IDLE,   // wait for an enable
		ST_START,  // start
		ST_ADDR_W, // slave address with w
		ST_REG,    // register address
		ST_DATA,   // write data byte
		ST_RSTART, // repeated start
		ST_ADDR_R, // slave address with r
		ST_READ,   // one byte in with nack
		ST_STOP,   // stop
		ST_SETTLE, // post write wait
		ST_FINISH  // hold until enables drop
	} state_t;

	state_t                state;
	state_t                step_next;
	mpr121_pkg::i2c_cmd_e  step_cmd;
	mpr121_pkg::i2c_byte_u step_tx;
	mpr121_pkg::reg_byte_t reg_q;  // captured register address
	mpr121_pkg::reg_byte_t data_q; // captured write data
	logic                  is_rd;   // read transaction
	logic                  pending; // command out and no done yet
	logic                  cmd_state;
	logic                  issue;
	logic                  need_ack;
	logic [SW-1:0]         settle_cnt;

	assign cmd_state = state inside {ST_START, ST_ADDR_W, ST_REG, ST_DATA,
		ST_RSTART, ST_ADDR_R, ST_READ, ST_STOP};
	assign issue = cmd_state && !pending;
	assign need_ack = state inside {ST_ADDR_W, ST_REG, ST_DATA, ST_ADDR_R}; // bytes we send

	// command, byte and successor of each command state
	always_comb
	begin
		step_cmd = mpr121_pkg::CMD_WRITE;
		step_tx.raw = '0;
		step_next = ST_STOP;
		case (state)
			ST_START:
			begin
				step_cmd = mpr121_pkg::CMD_START;
				step_next = ST_ADDR_W;
			end
			ST_ADDR_W, ST_ADDR_R:
			begin
				step_tx.addr_rw.addr = `MPR121_I2C_ADDR;
				step_tx.addr_rw.rw = (state == ST_ADDR_R);
				step_next = (state == ST_ADDR_R) ? ST_READ : ST_REG;
			end
			ST_REG:
			begin
				step_tx.raw = reg_q;
				step_next = is_rd ? ST_RSTART : ST_DATA; // read turns the bus around
			end
			ST_DATA:
			begin
				step_tx.raw = data_q;
			end
			ST_RSTART:
			begin
				step_cmd = mpr121_pkg::CMD_START;
				step_next = ST_ADDR_R;
			end
			ST_READ:
			begin
				step_cmd = mpr121_pkg::CMD_READ;
			end
			ST_STOP:
			begin
				step_cmd = mpr121_pkg::CMD_STOP;
				step_next = is_rd ? ST_FINISH : ST_SETTLE;
			end
			default:
			begin
				step_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state <= ST_IDLE;
			is_rd <= 1'b0;
			pending <= 1'b0;
			cmd_valid <= 1'b0;
			cmd <= mpr121_pkg::CMD_START;
			busy <= 1'b0;
			fail <= 1'b0;
			data_out <= '0;
			settle_cnt <= '0;
		end
		else
		begin
			cmd_valid <= issue; // one pulse per command state
			if (issue)
			begin
				cmd <= step_cmd;
				pending <= 1'b1;
			end
			case (state)
				ST_IDLE:
				begin
					if (write_enable || read_enable)
					begin
						busy <= 1'b1;
						fail <= 1'b0;
						data_out <= '0;
						is_rd <= !write_enable; // write wins a tie
						state <= ST_START;
					end
				end
				ST_START, ST_ADDR_W, ST_REG, ST_DATA, ST_RSTART, ST_ADDR_R, ST_READ, ST_STOP:
				begin
					if (pending && done)
					begin
						pending <= 1'b0;
						if (need_ack && !ack_in)
						begin
							fail <= 1'b1; // missed ack goes straight to stop
							state <= ST_STOP;
						end
						else
						begin
							state <= step_next;
						end
						if (state == ST_READ)
						begin
							data_out <= rx_byte.raw;
						end
						if ((state == ST_STOP) && is_rd)
						begin
							busy <= 1'b0; // read ends with its stop
						end
						settle_cnt <= '0;
					end
				end
				ST_SETTLE:
				begin
					if (settle_cnt == SW'(`WRITE_SETTLE_CYCLES - 1))
					begin
						busy <= 1'b0;
						state <= ST_FINISH;
					end
					else
					begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
				ST_FINISH:
				begin
					if (!write_enable && !read_enable)
					begin
						state <= ST_IDLE; // held enable never restarts
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE)
		begin
			reg_q <= reg_addr;
			data_q <= data_in;
		end
		if (issue)
		begin
			tx_byte <= step_tx;
		end
	end

	// engine handshake is one command at a time
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rstn)
		cmd_valid |=> !cmd_valid);

	// no bus activity outside a host transaction
	a_valid_busy: assert property (@(posedge clk) disable iff (!rstn)
		cmd_valid |-> busy);

endmodule

// ==== hdl/mpr121_controller.sv ====
`timescale 1ns/10ps

module mpr121_controller (
	input  logic                  clk,
	input  logic                  rstn,
	input  mpr121_pkg::reg_byte_t reg_addr,
	input  mpr121_pkg::reg_byte_t data_in,
	input  logic                  write_enable,
	input  logic                  read_enable,
	output mpr121_pkg::reg_byte_t data_out,
	output logic                  busy,
	output logic                  fail,
	inout  wire                   i2c_scl,
	inout  wire                   i2c_sda
);
	mpr121_pkg::i2c_cmd_e  cmd;
	mpr121_pkg::i2c_byte_u tx_byte;
	mpr121_pkg::i2c_byte_u rx_byte;
	logic                  cmd_valid;
	logic                  done;
	logic                  ack_in;
	logic                  scl_oe;
	logic                  sda_oe;
	logic                  sda_in;

	mpr121_sequencer u_sequencer (
		.clk          (clk),
		.rstn         (rstn),
		.reg_addr     (reg_addr),
		.data_in      (data_in),
		.write_enable (write_enable),
		.read_enable  (read_enable),
		.done         (done),
		.ack_in       (ack_in),
		.rx_byte      (rx_byte),
		.data_out     (data_out),
		.busy         (busy),
		.fail         (fail),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.tx_byte      (tx_byte)
	);

	i2c_bit_engine u_engine (
		.clk       (clk),
		.rstn      (rstn),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.tx_byte   (tx_byte),
		.sda_in    (sda_in),
		.done      (done),
		.ack_in    (ack_in),
		.rx_byte   (rx_byte),
		.scl_oe    (scl_oe),
		.sda_oe    (sda_oe)
	);

	// open drain pads pulled up off chip
	assign i2c_scl = scl_oe ? 1'b0 : 1'bz;
	assign i2c_sda = sda_oe ? 1'b0 : 1'bz;
	assign sda_in = i2c_sda; // ack and read data come back here

endmodule

// ==== tb/mpr121_slave_model.sv ====
`timescale 1ns/10ps

module mpr121_slave_model (
	input  logic clk,
	input  logic rstn,
	input  logic nack_addr, // refuse the next address byte
	input  wire  scl,
	inout  wire  sda
);
	localparam logic [2:0] PH_IDLE  = 3'd0; // not addressed
	localparam logic [2:0] PH_ADDR  = 3'd1; // address byte after a start
	localparam logic [2:0] PH_PTR   = 3'd2; // register pointer byte
	localparam logic [2:0] PH_WDATA = 3'd3; // data bytes into the register file
	localparam logic [2:0] PH_RDATA = 3'd4; // register byte out to the master

	logic [7:0] regs [256];
	logic [2:0] phase;
	logic [3:0] cnt;   // bits of the current byte, 9 in the ack bit
	logic [7:0] sh;
	logic [7:0] ptr;   // register pointer
	logic       rw;
	logic       drive; // pull sda low
	logic       scl_q;
	logic       sda_q;

	assign sda = drive ? 1'b0 : 1'bz;

	// bus sampled on clk so edges are seen one cycle late
	always @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			for (int i = 0; i < 256; i++)
			begin
				regs[i] <= 8'(i) ^ 8'h5a; // power-up pattern per register
			end
			phase <= PH_IDLE;
			cnt <= 4'd0;
			sh <= 8'h00;
			ptr <= 8'h00;
			rw <= 1'b0;
			drive <= 1'b0;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
		end
		else
		begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl_q && scl && sda_q && !sda)
			begin
				phase <= PH_ADDR; // start or repeated start
				cnt <= 4'd0;
				drive <= 1'b0;
			end
			else if (scl_q && scl && !sda_q && sda)
			begin
				phase <= PH_IDLE; // stop
				drive <= 1'b0;
			end
			else if (!scl_q && scl)
			begin
				if ((phase inside {PH_ADDR, PH_PTR, PH_WDATA}) && (cnt < 4'd8))
				begin
					sh <= {sh[6:0], sda}; // msb first
					cnt <= cnt + 4'd1;
				end
			end
			else if (scl_q && !scl)
			begin
				case (phase)
					PH_ADDR, PH_PTR, PH_WDATA:
					begin
						if (cnt == 4'd8)
						begin
							cnt <= 4'd9; // byte complete, ack bit next
							drive <= 1'b1;
							if (phase == PH_ADDR)
							begin
								rw <= sh[0];
								if ((sh[7:1] != 7'h5b) || nack_addr)
								begin
									drive <= 1'b0; // leave sda high
									phase <= PH_IDLE;
								end
							end
							else if (phase == PH_PTR)
							begin
								ptr <= sh;
							end
							else
							begin
								regs[ptr] <= sh;
								ptr <= ptr + 8'd1; // auto increment
							end
						end
						else if (cnt == 4'd9)
						begin
							cnt <= 4'd0;
							drive <= 1'b0;
							if ((phase == PH_ADDR) && rw)
							begin
								phase <= PH_RDATA;
								drive <= !regs[ptr][7]; // first bit right away
								sh <= {regs[ptr][6:0], 1'b0};
								cnt <= 4'd1;
							end
							else
							begin
								phase <= (phase == PH_ADDR) ? PH_PTR : PH_WDATA;
							end
						end
					end
					PH_RDATA:
					begin
						if (cnt < 4'd8)
						begin
							drive <= !sh[7];
							sh <= {sh[6:0], 1'b0};
							cnt <= cnt + 4'd1;
						end
						else
						begin
							drive <= 1'b0; // master answers, single byte only
							phase <= PH_IDLE;
						end
					end
					default:
					begin
						drive <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

// ==== tb/tb_mpr121.sv ====
`timescale 1ns/10ps
`include "mpr121_defines.svh"

module tb_mpr121;
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 5; // after each rising edge
	localparam int RANDOM_PAIRS = 8;
	// longest transaction is a read with 7 commands of up to 36 quarters
	localparam int MAX_TXN_CYCLES = 7 * 36 * `I2C_PRESCALE + `WRITE_SETTLE_CYCLES;
	localparam int WAIT_LIMIT = 2 * MAX_TXN_CYCLES;
	localparam int COND_QTRS = 4;     // start or stop
	localparam int BYTE_QTRS = 9 * 4; // eight bits and the ack bit

	logic                  clk;
	logic                  rstn;
	mpr121_pkg::reg_byte_t reg_addr;
	mpr121_pkg::reg_byte_t data_in;
	logic                  write_enable;
	logic                  read_enable;
	mpr121_pkg::reg_byte_t data_out;
	logic                  busy;
	logic                  fail;
	logic                  nack_addr;
	wire                   i2c_scl;
	wire                   i2c_sda;

	mpr121_pkg::reg_byte_t shadow [256]; // expected register file
	logic [7:0]            vec_op [$];
	logic [7:0]            vec_reg [$];
	logic [7:0]            vec_data [$];
	logic [7:0]            vec_exp [$];
	int                    seed;
	int                    test_num;
	int                    test_errs;
	int                    pass_count;
	int                    fail_count;
	int                    n_tests;
	int                    watch_ns;
	logic                  vectors_loaded;

	pullup (i2c_scl);
	pullup (i2c_sda);

	mpr121_controller DUT (
		.clk          (clk),
		.rstn         (rstn),
		.reg_addr     (reg_addr),
		.data_in      (data_in),
		.write_enable (write_enable),
		.read_enable  (read_enable),
		.data_out     (data_out),
		.busy         (busy),
		.fail         (fail),
		.i2c_scl      (i2c_scl),
		.i2c_sda      (i2c_sda)
	);

	mpr121_slave_model u_slave (
		.clk       (clk),
		.rstn      (rstn),
		.nack_addr (nack_addr),
		.scl       (i2c_scl),
		.sda       (i2c_sda)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY; // outputs settled before inputs move
	endtask

	task automatic check_byte(input string name, input mpr121_pkg::reg_byte_t got,
		input mpr121_pkg::reg_byte_t exp);
		if (got !== exp)
		begin
			$display("ERROR test %0d %s got 0x%h expected 0x%h", test_num, name, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR test %0d %s got 0x%h expected 0x%h", test_num, name, got, exp);
			test_errs++;
		end
	endtask

	task automatic report_test(input string kind, input mpr121_pkg::reg_byte_t addr,
		input mpr121_pkg::reg_byte_t wdata);
		string verdict;
		if (test_errs == 0)
		begin
			verdict = "ok";
			pass_count++;
		end
		else
		begin
			verdict = "failed";
			fail_count++;
		end
		$display("test %0d %s reg 0x%h data 0x%h %s", test_num, kind, addr, wdata, verdict);
	endtask

	// shortest busy time from the fixed command lengths
	function automatic int min_busy_cycles(input logic is_write, input logic nack);
		int quarters;
		if (!is_write)
		begin
			// start addr reg rstart addr read stop
			quarters = 3 * COND_QTRS + 4 * BYTE_QTRS;
		end
		else if (nack)
		begin
			quarters = 2 * COND_QTRS + BYTE_QTRS; // stop right after the address
		end
		else
		begin
			quarters = 2 * COND_QTRS + 3 * BYTE_QTRS;
		end
		min_busy_cycles = quarters * `I2C_PRESCALE;
		if (is_write)
		begin
			min_busy_cycles += `WRITE_SETTLE_CYCLES; // settle only after writes
		end
	endfunction

	// one host request from enable to release of the enable
	task automatic run_request(input string kind, input logic is_write,
		input mpr121_pkg::reg_byte_t addr, input mpr121_pkg::reg_byte_t wdata,
		input logic nack, input mpr121_pkg::reg_byte_t exp_byte, input logic exp_fail);
		int cycles;
		test_num++;
		test_errs = 0;
		check_flag("busy", busy, 1'b0); // idle before the enable
		reg_addr = addr;
		data_in = wdata;
		nack_addr = nack;
		write_enable = is_write;
		read_enable = !is_write;
		next_cycle();
		check_flag("busy", busy, 1'b1); // one cycle after the enable
		cycles = 0;
		while ((busy === 1'b1) && (cycles < WAIT_LIMIT))
		begin
			next_cycle();
			cycles++;
		end
		if (busy !== 1'b0)
		begin
			$display("test %0d busy never fell within %0d cycles", test_num, WAIT_LIMIT);
			test_errs++;
		end
		else
		begin
			if (cycles < min_busy_cycles(is_write, nack))
			begin
				$display("test %0d busy fell after %0d cycles which is shorter than the %0d needed",
					test_num, cycles, min_busy_cycles(is_write, nack));
				test_errs++;
			end
			check_flag("fail", fail, exp_fail);
			check_flag("i2c_scl", i2c_scl, 1'b1); // stop sent so bus is free
			check_flag("i2c_sda", i2c_sda, 1'b1);
			if (!is_write)
			begin
				check_byte("data_out", data_out, exp_byte);
			end
			repeat (3)
			begin
				next_cycle();
				check_flag("busy", busy, 1'b0); // enable still held
			end
		end
		write_enable = 1'b0;
		read_enable = 1'b0;
		nack_addr = 1'b0;
		repeat (2) next_cycle();
		report_test(kind, addr, wdata);
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		logic [7:0] op;
		logic [7:0] r;
		logic [7:0] d;
		logic [7:0] e;
		fd = $fopen("tb/mpr121_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("could not open tb/mpr121_vectors.txt, no vector tests run");
			fail_count++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				// comment and blank lines skipped
				if ((n > 0) && (line.getc(0) != "#") &&
					($sscanf(line, "%c %h %h %h", op, r, d, e) == 4))
				begin
					vec_op.push_back(op);
					vec_reg.push_back(r);
					vec_data.push_back(d);
					vec_exp.push_back(e);
				end
			end
			$fclose(fd);
		end
	endtask

	initial
	begin
		wait (vectors_loaded);
		#(watch_ns);
		$display("watchdog stopped the run after %0d ns", watch_ns);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		mpr121_pkg::reg_byte_t r;
		mpr121_pkg::reg_byte_t d;
		clk = 1'b0;
		rstn = 1'b0;
		reg_addr = 8'h00;
		data_in = 8'h00;
		write_enable = 1'b0;
		read_enable = 1'b0;
		nack_addr = 1'b0;
		vectors_loaded = 1'b0;
		seed = 32'hc8fa;
		test_num = 0;
		test_errs = 0;
		pass_count = 0;
		fail_count = 0;
		for (int i = 0; i < 256; i++)
		begin
			shadow[i] = 8'(i) ^ 8'h5a; // slave power-up contents
		end
		load_vectors();
		n_tests = 1 + vec_op.size() + 2 * RANDOM_PAIRS;
		watch_ns = (n_tests * WAIT_LIMIT + 20) * CLK_PERIOD;
		vectors_loaded = 1'b1;

		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		rstn = 1'b1;
		test_num++;
		test_errs = 0;
		check_flag("busy", busy, 1'b0);
		check_flag("fail", fail, 1'b0);
		check_byte("data_out", data_out, 8'h00);
		check_flag("i2c_scl", i2c_scl, 1'b1);
		check_flag("i2c_sda", i2c_sda, 1'b1);
		report_test("reset", 8'h00, 8'h00);
		next_cycle();

		for (int k = 0; k < vec_op.size(); k++)
		begin
			case (vec_op[k])
				"W":
				begin
					run_request("W", 1'b1, vec_reg[k], vec_data[k], 1'b0, 8'h00, vec_exp[k][0]);
					shadow[vec_reg[k]] = vec_data[k];
				end
				"R": run_request("R", 1'b0, vec_reg[k], 8'h00, 1'b0, vec_exp[k], 1'b0);
				"N": run_request("N", 1'b1, vec_reg[k], vec_data[k], 1'b1, 8'h00, vec_exp[k][0]);
				default:
				begin
					$display("vector line %0d has an unknown operation", k);
					fail_count++;
				end
			endcase
		end

		for (int p = 0; p < RANDOM_PAIRS; p++)
		begin
			r = mpr121_pkg::reg_byte_t'($random(seed));
			d = mpr121_pkg::reg_byte_t'($random(seed));
			shadow[r] = d;
			run_request("random W", 1'b1, r, d, 1'b0, 8'h00, 1'b0);
			run_request("random R", 1'b0, r, 8'h00, 1'b0, shadow[r], 1'b0);
		end

		$display("tests %0d passed %0d failed %0d", test_num, pass_count, fail_count);
		if (fail_count == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== tb/mpr121_vectors.txt ====
# columns are op reg data expect in hex
# expect is the fail flag for W and N and the read byte for R
R 00 00 5a
R 5b 00 01
R ff 00 a5
R 7f 00 25
W 5e 3c 00
R 5e 00 3c
W 41 0f 00
R 41 00 0f
N 41 77 01
R 41 00 0f
N 2b 99 01
R 2b 00 71
W 80 ff 00
R 80 00 ff
W 80 00 00
R 80 00 00
W 2c 1e 00
W 2d 2f 00
R 2c 00 1e
R 2d 00 2f

// ==== all.f ====
+incdir+hdl
hdl/mpr121_pkg.sv
hdl/i2c_bit_engine.sv
hdl/mpr121_sequencer.sv
hdl/mpr121_controller.sv
tb/mpr121_slave_model.sv
tb/tb_mpr121.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f all.f --top-module tb_mpr121 -o tb_mpr121 &&
./obj_dir/tb_mpr121 > sim.log 2>&1 ||
echo "build or simulation returned an error"
grep -q "ALL TESTS PASSED" sim.log && echo "result pass" || { echo "result fail, see sim.log"; exit 1; }
